//--- all.f
+incdir+testbench
hw/csr_pkg.sv
hw/csr_cmd_if.sv
hw/csr_evt_if.sv
hw/csr_decode.sv
hw/csr_regfile.sv
hw/csr_result.sv
hw/csr_top.sv
testbench/tb_csr_top.sv

//--- testbench/tb_csr_tasks.svh
`ifndef TB_CSR_TASKS_SVH
`define TB_CSR_TASKS_SVH

// ========================================================================
// error reporting
// ========================================================================
task automatic log_mismatch(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    mismatch_count++;
    $display("Mismatch at %0d ns: %s = %h, expected %h", $time, name, got, exp);
endtask

task automatic note_failure(input string what);
    failure_count++;
    $display("Error at %0d ns: %s", $time, what);
endtask

// ========================================================================
// model helpers
// ========================================================================
// ops that read and write the csr
function automatic logic is_csr_op(input csr_op_e op);
    return (op == op_read_write) || (op == op_set) || (op == op_clear);
endfunction

function automatic logic is_known(input logic [11:0] addr);
    case (addr)
        csr_mvendorid, csr_marchid, csr_mimpid, csr_mhartid,
        csr_mstatus, csr_misa, csr_mie, csr_mtvec,
        csr_mepc, csr_mcause, csr_mtval, csr_mip,
        csr_mcycle, csr_mcycleh: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

// model value of a csr, window and unknown read zero
function automatic logic [31:0] expected_read(input logic [11:0] addr);
    case (addr)
        csr_marchid: return pito_marchid;
        csr_mhartid: return hart_id;
        csr_misa:    return isa_code;
        csr_mstatus: return r_mstatus;
        csr_mie:     return r_mie;
        csr_mtvec:   return r_mtvec;
        csr_mepc:    return r_mepc;
        csr_mcause:  return r_mcause;
        csr_mtval:   return r_mtval;
        // only the mvu pending bit ever gets set
        csr_mip:     return {15'd0, r_pend, 16'd0};
        csr_mcycle:  return r_cycle[31:0];
        csr_mcycleh: return r_cycle[63:32];
        default:     return 32'd0;
    endcase
endfunction

// ========================================================================
// stimulus
// ========================================================================
// hold one command for a cycle, return 5 ns past the next edge
task automatic access_csr(input csr_op_e op, input logic [11:0] addr,
                          input logic [31:0] wdata);
    csr_op_i    = op;
    csr_addr_i  = addr;
    csr_wdata_i = wdata;
    @(posedge clk);
    #5;
endtask

// set with zero leaves the value as it is
task automatic read_csr(input logic [11:0] addr);
    access_csr(op_set, addr, 32'd0);
endtask

task automatic idle_cycles(input int n);
    csr_op_i    = csr_op_e'(3'd0);
    csr_wdata_i = 32'd0;
    repeat (n) begin
        @(posedge clk);
        #5;
    end
endtask

// write, set and clear with random data, then read back
task automatic run_rmw(input logic [11:0] addr);
    access_csr(op_read_write, addr, $random(seed));
    access_csr(op_set, addr, $random(seed));
    access_csr(op_clear, addr, $random(seed));
    read_csr(addr);
endtask

task automatic wait_irq_event(input int limit);
    int n;
    n = 0;
    while (!irq_evt_valid_o && n < limit) begin
        @(posedge clk);
        #5;
        n++;
    end
    if (!irq_evt_valid_o) begin
        note_failure("no interrupt event came after the mvu interrupt pulse");
    end
endtask

`endif

//--- testbench/tb_csr_top.sv
`default_nettype none

module tb_csr_top;
    timeunit 1ns;
    timeprecision 1ps;

    import csr_pkg::*;

    logic        clk;
    logic        mtvec_rst_load_q;
    logic [11:0] csr_addr_i;
    csr_op_e     csr_op_i;
    logic [31:0] csr_wdata_i;
    logic [31:0] csr_rdata_o;
    logic [31:0] boot_addr_i;
    logic [31:0] pc_i;
    logic [31:0] cause_i;
    logic        enable_cycle_count_i;
    logic        mvu_irq_i;
    logic        exc_valid_o;
    logic [31:0] exc_cause_o;
    logic        irq_evt_valid_o;
    logic [31:0] irq_evt_data_o;
    logic [11:0] apb_paddr_o;
    logic        apb_psel_o;
    logic        apb_penable_o;
    logic        apb_pwrite_o;
    logic [31:0] apb_pwdata_o;

    // reference model state
    logic [31:0] r_mstatus, r_mie, r_mtvec, r_mepc, r_mcause, r_mtval;
    logic        r_pend;
    logic [63:0] r_cycle;
    // expected values for the cycle in flight
    logic        ref_csr_op, ref_exc, ref_take, ref_evt;
    logic [31:0] ref_rd, ref_wv, ref_tvec, ref_evt_data;
    // apb beat expected one cycle after a window write
    logic        apb_exp;
    logic [11:0] apb_addr_exp;
    logic [31:0] apb_data_exp;
    logic        rst_d = 1'b0;
    int          mismatch_count;
    int          failure_count;
    integer      seed;

    `include "tb_csr_tasks.svh"

    always #50 clk = ~clk;

    csr_top UUT (.*);

    // ========================================================================
    // reference model
    // ========================================================================
    always_comb begin
        ref_csr_op = is_csr_op(csr_op_i);
        ref_rd     = ref_csr_op ? expected_read(csr_addr_i) : 32'd0;
        case (csr_op_i)
            op_set:   ref_wv = csr_wdata_i | ref_rd;
            op_clear: ref_wv = ref_rd & ~csr_wdata_i;
            default:  ref_wv = csr_wdata_i;
        endcase
        ref_exc  = ref_csr_op && !is_known(csr_addr_i) && (csr_addr_i < mvu_csr_start);
        // global mie, mvu pending, mvu enabled
        ref_take = r_mstatus[3] && r_pend && r_mie[16];
        // trap goes to the mtvec value written this cycle if there is one
        ref_tvec = (ref_csr_op && csr_addr_i == csr_mtvec) ? ref_wv : r_mtvec;
        ref_evt  = (csr_op_i == op_mret) || ref_take;
        ref_evt_data = (csr_op_i == op_mret) ? r_mepc : ref_tvec;
    end

    always @(posedge clk) begin
        rst_d <= mtvec_rst_load_q;
        if (mtvec_rst_load_q) begin
            r_mstatus <= 32'd0;
            r_mie     <= 32'd0;
            r_pend    <= 1'b0;
            r_mtvec   <= boot_addr_i;
            r_mepc    <= 32'd0;
            r_mcause  <= 32'd0;
            r_mtval   <= 32'd0;
            r_cycle   <= 64'd0;
            apb_exp   <= 1'b0;
        end else begin
            r_cycle      <= r_cycle + {63'd0, enable_cycle_count_i};
            r_pend       <= r_pend | mvu_irq_i;
            apb_exp      <= ref_csr_op && (csr_addr_i >= mvu_csr_start);
            apb_addr_exp <= csr_addr_i;
            apb_data_exp <= ref_wv;
            if (ref_csr_op) begin
                case (csr_addr_i)
                    // sd, xs, fs, upie, uie read as zero
                    csr_mstatus: r_mstatus <= ref_wv & ~32'h8001_E011;
                    // msi, mti, mei and mvu bits only
                    csr_mie:     r_mie <= (r_mie & ~32'h0001_0888) | (ref_wv & 32'h0001_0888);
                    csr_mtvec:   r_mtvec <= ref_wv;
                    csr_mepc:    r_mepc <= {ref_wv[31:1], 1'b0};
                    csr_mcause:  r_mcause <= ref_wv;
                    csr_mtval:   r_mtval <= ref_wv;
                    default: ;
                endcase
            end
            if (ref_take) begin
                r_mstatus[7] <= r_mstatus[3];
                r_mstatus[3] <= 1'b0;
                r_mcause     <= {1'b1, 26'd0, cause_i[4:0]};
                r_mepc       <= pc_i;
            end
            if (csr_op_i == op_mret) begin
                r_mstatus[7] <= 1'b1;
            end
        end
    end

    // ========================================================================
    // checks
    // ========================================================================
    rdata_ok: assert property (@(posedge clk) disable iff (mtvec_rst_load_q)
        csr_rdata_o == ref_rd)
        else log_mismatch("csr_rdata_o", $sampled(csr_rdata_o), $sampled(ref_rd));
    exc_valid_ok: assert property (@(posedge clk) disable iff (mtvec_rst_load_q)
        exc_valid_o == ref_exc)
        else log_mismatch("exc_valid_o", $sampled(exc_valid_o), $sampled(ref_exc));
    exc_cause_ok: assert property (@(posedge clk) disable iff (mtvec_rst_load_q)
        ref_exc |-> exc_cause_o == 32'd2)
        else log_mismatch("exc_cause_o", $sampled(exc_cause_o), 32'd2);
    evt_valid_ok: assert property (@(posedge clk) disable iff (mtvec_rst_load_q)
        irq_evt_valid_o == ref_evt)
        else log_mismatch("irq_evt_valid_o", $sampled(irq_evt_valid_o), $sampled(ref_evt));
    evt_data_ok: assert property (@(posedge clk) disable iff (mtvec_rst_load_q)
        ref_evt |-> irq_evt_data_o == ref_evt_data)
        else log_mismatch("irq_evt_data_o", $sampled(irq_evt_data_o), $sampled(ref_evt_data));
    // select, enable and write move together
    apb_ctrl_ok: assert property (@(posedge clk) disable iff (mtvec_rst_load_q)
        {apb_psel_o, apb_penable_o, apb_pwrite_o} == {3{apb_exp}})
        else log_mismatch("apb_psel_o/apb_penable_o/apb_pwrite_o",
                          $sampled({apb_psel_o, apb_penable_o, apb_pwrite_o}),
                          $sampled({3{apb_exp}}));
    apb_addr_ok: assert property (@(posedge clk) disable iff (mtvec_rst_load_q)
        apb_exp |-> apb_paddr_o == apb_addr_exp)
        else log_mismatch("apb_paddr_o", $sampled(apb_paddr_o), $sampled(apb_addr_exp));
    apb_data_ok: assert property (@(posedge clk) disable iff (mtvec_rst_load_q)
        apb_exp |-> apb_pwdata_o == apb_data_exp)
        else log_mismatch("apb_pwdata_o", $sampled(apb_pwdata_o), $sampled(apb_data_exp));
    // flops are loaded by the second reset cycle
    reset_quiet: assert property (@(posedge clk)
        (mtvec_rst_load_q && rst_d) |-> !(apb_psel_o || apb_penable_o || apb_pwrite_o ||
                                           exc_valid_o || irq_evt_valid_o))
        else note_failure("an apb or valid output was high during reset");

    // ========================================================================
    // stimulus
    // ========================================================================
    initial begin
        seed                 = 32'h1684;
        clk                  = 1'b0;
        mtvec_rst_load_q     = 1'b1;
        csr_addr_i           = 12'd0;
        csr_op_i             = csr_op_e'(3'd0);
        csr_wdata_i          = 32'd0;
        boot_addr_i          = 32'h0000_8000;
        pc_i                 = 32'd0;
        cause_i              = 32'd0;
        enable_cycle_count_i = 1'b1;
        mvu_irq_i            = 1'b0;
        mismatch_count       = 0;
        failure_count        = 0;
        repeat (2) @(posedge clk);
        #5;
        mtvec_rst_load_q = 1'b0;

        // reset values
        read_csr(csr_mtvec);
        read_csr(csr_mstatus);
        read_csr(csr_mie);
        read_csr(csr_mip);
        read_csr(csr_mepc);

        // write rules and identity words
        run_rmw(csr_mtval);
        run_rmw(csr_mtvec);
        access_csr(op_read_write, csr_mepc, $random(seed));
        read_csr(csr_mepc);
        access_csr(op_read_write, csr_mstatus, 32'hFFFF_FFFF);
        read_csr(csr_mstatus);
        access_csr(op_read_write, csr_mie, 32'hFFFF_FFFF);
        read_csr(csr_mie);
        read_csr(csr_mvendorid);
        read_csr(csr_marchid);
        read_csr(csr_mimpid);
        read_csr(csr_mhartid);
        read_csr(csr_misa);

        // illegal addresses below the window and an mret that never traps
        access_csr(op_read_write, 12'h7C0, $random(seed));
        access_csr(op_clear, 12'hC00, 32'd0);
        access_csr(op_mret, 12'h7C0, 32'd0);

        // mvu window
        access_csr(op_read_write, mvu_csr_start, $random(seed));
        idle_cycles(2);
        access_csr(op_set, 12'hFFC, $random(seed));
        read_csr(12'hF40);
        idle_cycles(2);

        // interrupt entry and mret
        access_csr(op_read_write, csr_mtvec, 32'h0000_0400);
        access_csr(op_read_write, csr_mie, 32'h0001_0000);
        access_csr(op_read_write, csr_mstatus, 32'h0000_0008);
        // core pc is word aligned
        pc_i      = $random(seed) & 32'hFFFF_FFFC;
        cause_i   = $random(seed);
        mvu_irq_i = 1'b1;
        idle_cycles(1);
        mvu_irq_i = 1'b0;
        wait_irq_event(10);
        idle_cycles(1);
        read_csr(csr_mcause);
        read_csr(csr_mepc);
        read_csr(csr_mstatus);
        read_csr(csr_mip);
        // drop mpie so that the mret has to set it again
        access_csr(op_clear, csr_mstatus, 32'h0000_0080);
        read_csr(csr_mstatus);
        access_csr(op_mret, 12'd0, 32'd0);
        read_csr(csr_mstatus);

        // cycle counter running and then stopped
        read_csr(csr_mcycle);
        idle_cycles(5);
        read_csr(csr_mcycle);
        enable_cycle_count_i = 1'b0;
        idle_cycles(3);
        read_csr(csr_mcycle);
        read_csr(csr_mcycleh);
        idle_cycles(2);

        $display("mismatches: %0d, other errors: %0d", mismatch_count, failure_count);
        if (mismatch_count + failure_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hw/csr_top.sv
`default_nettype none

module csr_top (
    input  logic             clk,
    input  logic             mtvec_rst_load_q,
    // csr access
    input  logic [11:0]      csr_addr_i,
    input  csr_pkg::csr_op_e csr_op_i,
    input  logic [31:0]      csr_wdata_i,
    output logic [31:0]      csr_rdata_o,
    // core side
    input  logic [31:0]      boot_addr_i,
    input  logic [31:0]      pc_i,
    input  logic [31:0]      cause_i,
    input  logic             enable_cycle_count_i,
    input  logic             mvu_irq_i,
    output logic             exc_valid_o,
    output logic [31:0]      exc_cause_o,
    output logic             irq_evt_valid_o,
    output logic [31:0]      irq_evt_data_o,
    // mvu apb
    output logic [11:0]      apb_paddr_o,
    output logic             apb_psel_o,
    output logic             apb_penable_o,
    output logic             apb_pwrite_o,
    output logic [31:0]      apb_pwdata_o
);

    csr_cmd_if cmd_bus ();
    csr_evt_if evt_bus ();

    // ========================================================================
    // decode -> execute -> result
    // ========================================================================
    csr_decode u_decode (
        .csr_addr_i (csr_addr_i),
        .csr_op_i   (csr_op_i),
        .cmd        (cmd_bus.dec)
    );

    csr_regfile u_regfile (
        .clk                  (clk),
        .mtvec_rst_load_q     (mtvec_rst_load_q),
        .csr_addr_i           (csr_addr_i),
        .csr_op_i             (csr_op_i),
        .csr_wdata_i          (csr_wdata_i),
        .boot_addr_i          (boot_addr_i),
        .pc_i                 (pc_i),
        .cause_i              (cause_i),
        .enable_cycle_count_i (enable_cycle_count_i),
        .mvu_irq_i            (mvu_irq_i),
        .csr_rdata_o          (csr_rdata_o),
        .cmd                  (cmd_bus.exe),
        .evt                  (evt_bus.exe)
    );

    csr_result u_result (
        .clk              (clk),
        .mtvec_rst_load_q (mtvec_rst_load_q),
        .evt              (evt_bus.res),
        .exc_valid_o      (exc_valid_o),
        .exc_cause_o      (exc_cause_o),
        .irq_evt_valid_o  (irq_evt_valid_o),
        .irq_evt_data_o   (irq_evt_data_o),
        .apb_paddr_o      (apb_paddr_o),
        .apb_psel_o       (apb_psel_o),
        .apb_penable_o    (apb_penable_o),
        .apb_pwrite_o     (apb_pwrite_o),
        .apb_pwdata_o     (apb_pwdata_o)
    );

endmodule

`default_nettype wire

//--- hw/csr_result.sv
`default_nettype none

module csr_result (
    input  logic        clk,
    input  logic        mtvec_rst_load_q,
    csr_evt_if.res      evt,
    output logic        exc_valid_o,
    output logic [31:0] exc_cause_o,
    output logic        irq_evt_valid_o,
    output logic [31:0] irq_evt_data_o,
    output logic [11:0] apb_paddr_o,
    output logic        apb_psel_o,
    output logic        apb_penable_o,
    output logic        apb_pwrite_o,
    output logic [31:0] apb_pwdata_o
);
    import csr_pkg::*;

    // ========================================================================
    // exception and jump event, same cycle
    // ========================================================================
    assign exc_valid_o = evt.illegal;
    assign exc_cause_o = evt.illegal ? cause_illegal_instr : 32'd0;

    assign irq_evt_valid_o = evt.mret | evt.irq_take;

    // mret wins over a trap in the same cycle
    always_comb begin
        if (evt.mret) begin
            irq_evt_data_o = evt.return_target;
        end else if (evt.irq_take) begin
            irq_evt_data_o = evt.trap_target;
        end else begin
            irq_evt_data_o = 32'd0;
        end
    end

    // ========================================================================
    // apb write beat
    // ========================================================================
    // select, enable and write rise together for a single cycle
    always_ff @(posedge clk) begin
        if (mtvec_rst_load_q) begin
            apb_paddr_o   <= 12'd0;
            apb_pwdata_o  <= 32'd0;
            apb_psel_o    <= 1'b0;
            apb_penable_o <= 1'b0;
            apb_pwrite_o  <= 1'b0;
        end else if (evt.mvu_write) begin
            apb_paddr_o   <= evt.mvu_addr;
            apb_pwdata_o  <= evt.mvu_wdata;
            apb_psel_o    <= 1'b1;
            apb_penable_o <= 1'b1;
            apb_pwrite_o  <= 1'b1;
        end else begin
            // bus idles at zero
            apb_paddr_o   <= 12'd0;
            apb_pwdata_o  <= 32'd0;
            apb_psel_o    <= 1'b0;
            apb_penable_o <= 1'b0;
            apb_pwrite_o  <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- hw/csr_regfile.sv
`default_nettype none

module csr_regfile (
    input  logic             clk,
    input  logic             mtvec_rst_load_q,
    input  logic [11:0]      csr_addr_i,
    input  csr_pkg::csr_op_e csr_op_i,
    input  logic [31:0]      csr_wdata_i,
    input  logic [31:0]      boot_addr_i,
    input  logic [31:0]      pc_i,
    input  logic [31:0]      cause_i,
    input  logic             enable_cycle_count_i,
    input  logic             mvu_irq_i,
    output logic [31:0]      csr_rdata_o,
    csr_cmd_if.exe           cmd,
    csr_evt_if.exe           evt
);
    import csr_pkg::*;

    mstatus_t    mstatus_q, mstatus_d;
    logic [31:0] mie_q, mie_d;
    logic [31:0] mip_q, mip_d;
    logic [31:0] mtvec_q, mtvec_d;
    logic [31:0] mepc_q, mepc_d;
    logic [31:0] mcause_q, mcause_d;
    logic [31:0] mtval_q, mtval_d;
    logic [63:0] mcycle_q, mcycle_d;

    logic [31:0] rdata;
    logic [31:0] wval;
    csr_word_u   rd_word;
    csr_word_u   wr_word;
    logic        mip_wr;
    logic        irq_take;

    // ========================================================================
    // read mux
    // ========================================================================
    always_comb begin
        rd_word.status = mstatus_q;
        rdata          = 32'd0;
        if (cmd.read_en) begin
            case (cmd.sel)
                sel_mvendorid: rdata = 32'd0;
                sel_marchid:   rdata = pito_marchid;
                sel_mimpid:    rdata = 32'd0;
                sel_mhartid:   rdata = hart_id;
                sel_mstatus:   rdata = rd_word.raw;
                sel_misa:      rdata = isa_code;
                sel_mie:       rdata = mie_q;
                sel_mtvec:     rdata = mtvec_q;
                sel_mepc:      rdata = mepc_q;
                sel_mcause:    rdata = mcause_q;
                sel_mtval:     rdata = mtval_q;
                sel_mip:       rdata = mip_q;
                sel_mcycle:    rdata = mcycle_q[31:0];
                sel_mcycleh:   rdata = mcycle_q[63:32];
                // mvu window and unknown addresses read zero
                default:       rdata = 32'd0;
            endcase
        end
    end

    assign csr_rdata_o = rdata;

    // write value by op
    always_comb begin
        case (csr_op_i)
            op_set:   wval = csr_wdata_i | rdata;
            op_clear: wval = rdata & ~csr_wdata_i;
            default:  wval = csr_wdata_i;
        endcase
    end

    // mvu pending, enabled, and global enable on
    assign irq_take = mstatus_q.mie & mip_q[irq_mvu_bit] & mie_q[irq_mvu_bit];

    // ========================================================================
    // next state
    // ========================================================================
    always_comb begin
        mstatus_d   = mstatus_q;
        mie_d       = mie_q;
        mip_d       = mip_q;
        mtvec_d     = mtvec_q;
        mepc_d      = mepc_q;
        mcause_d    = mcause_q;
        mtval_d     = mtval_q;
        mip_wr      = 1'b0;
        wr_word.raw = wval;

        // free running while enabled
        mcycle_d = enable_cycle_count_i ? mcycle_q + 64'd1 : mcycle_q;

        // identity, misa and counter writes are dropped silently
        if (cmd.write_en) begin
            case (cmd.sel)
                sel_mstatus: begin
                    mstatus_d      = wr_word.status;
                    // no user mode, no fp or custom extension state
                    mstatus_d.xs   = 2'b00;
                    mstatus_d.fs   = 2'b00;
                    mstatus_d.upie = 1'b0;
                    mstatus_d.uie  = 1'b0;
                end
                sel_mie:    mie_d    = (mie_q & ~irq_mask) | (wval & irq_mask);
                sel_mtvec:  mtvec_d  = wval;
                sel_mepc:   mepc_d   = {wval[31:1], 1'b0};
                sel_mcause: mcause_d = wval;
                sel_mtval:  mtval_d  = wval;
                sel_mip: begin
                    mip_d  = (mip_q & ~irq_mask) | (wval & irq_mask);
                    mip_wr = 1'b1;
                end
                default: ;
            endcase
        end

        // sticky mvu pending, a direct mip write takes priority
        mip_d[irq_mvu_bit] = mip_wr ? wval[irq_mvu_bit] : (mip_q[irq_mvu_bit] | mvu_irq_i);

        // trap entry
        if (irq_take) begin
            mstatus_d.mpie = mstatus_q.mie;
            mstatus_d.mie  = 1'b0;
            mcause_d       = {1'b1, 26'd0, cause_i[4:0]};
            mepc_d         = pc_i;
        end

        // return, mie is left to software
        if (cmd.mret) begin
            mstatus_d.mpie = 1'b1;
        end

        // sd hardwired
        mstatus_d.sd = 1'b0;
    end

    // ========================================================================
    // state
    // ========================================================================
    always_ff @(posedge clk) begin
        if (mtvec_rst_load_q) begin
            mstatus_q <= '0;
            mie_q     <= 32'd0;
            mip_q     <= 32'd0;
            // boot address loaded for as long as reset is held
            mtvec_q   <= boot_addr_i;
            mepc_q    <= 32'd0;
            mcause_q  <= 32'd0;
            mtval_q   <= 32'd0;
            mcycle_q  <= 64'd0;
        end else begin
            mstatus_q <= mstatus_d;
            mie_q     <= mie_d;
            mip_q     <= mip_d;
            mtvec_q   <= mtvec_d;
            mepc_q    <= mepc_d;
            mcause_q  <= mcause_d;
            mtval_q   <= mtval_d;
            mcycle_q  <= mcycle_d;
        end
    end

    // events to result stage
    assign evt.illegal       = cmd.illegal;
    assign evt.mvu_write     = cmd.write_en & cmd.mvu_access;
    assign evt.mvu_addr      = csr_addr_i;
    assign evt.mvu_wdata     = wval;
    assign evt.irq_take      = irq_take;
    assign evt.mret          = cmd.mret;
    assign evt.trap_target   = mtvec_d;
    assign evt.return_target = mepc_q;

endmodule

`default_nettype wire

//--- hw/csr_decode.sv
`default_nettype none

module csr_decode (
    input  logic [11:0]      csr_addr_i,
    input  csr_pkg::csr_op_e csr_op_i,
    csr_cmd_if.dec           cmd
);
    import csr_pkg::*;

    logic     rd_en;
    logic     wr_en;
    logic     is_mret;
    logic     in_window;
    csr_sel_e sel;

    // ========================================================================
    // op code
    // ========================================================================
    always_comb begin
        rd_en   = 1'b0;
        wr_en   = 1'b0;
        is_mret = 1'b0;
        case (csr_op_i)
            // every csr op reads and writes, set/clear need the old value
            op_read_write, op_set, op_clear: begin
                rd_en = 1'b1;
                wr_en = 1'b1;
            end
            // no read or write side effects on return
            op_mret: is_mret = 1'b1;
            default: ;
        endcase
    end

    // ========================================================================
    // address map
    // ========================================================================
    assign in_window = (csr_addr_i >= mvu_csr_start);

    always_comb begin
        case (csr_addr_i)
            csr_mvendorid: sel = sel_mvendorid;
            csr_marchid:   sel = sel_marchid;
            csr_mimpid:    sel = sel_mimpid;
            csr_mhartid:   sel = sel_mhartid;
            csr_mstatus:   sel = sel_mstatus;
            csr_misa:      sel = sel_misa;
            csr_mie:       sel = sel_mie;
            csr_mtvec:     sel = sel_mtvec;
            csr_mepc:      sel = sel_mepc;
            csr_mcause:    sel = sel_mcause;
            csr_mtval:     sel = sel_mtval;
            csr_mip:       sel = sel_mip;
            csr_mcycle:    sel = sel_mcycle;
            csr_mcycleh:   sel = sel_mcycleh;
            // unknown, or inside the mvu window
            default:       sel = sel_none;
        endcase
    end

    // ========================================================================
    // command out
    // ========================================================================
    assign cmd.read_en    = rd_en;
    assign cmd.write_en   = wr_en;
    assign cmd.mret       = is_mret;
    assign cmd.sel        = sel;
    assign cmd.mvu_access = in_window;
    // window addresses never trap, reads there just return zero
    assign cmd.illegal    = (rd_en | wr_en) & (sel == sel_none) & ~in_window;

endmodule

`default_nettype wire

//--- hw/csr_evt_if.sv
`default_nettype none

// per-cycle events, execute -> result
interface csr_evt_if;

    logic        illegal;
    // mvu window write, registered later into one apb beat
    logic        mvu_write;
    logic [11:0] mvu_addr;
    logic [31:0] mvu_wdata;
    // trap entry and return
    logic        irq_take;
    logic        mret;
    logic [31:0] trap_target;
    logic [31:0] return_target;

    modport exe (
        output illegal, mvu_write, mvu_addr, mvu_wdata,
        output irq_take, mret, trap_target, return_target
    );

    modport res (
        input  illegal, mvu_write, mvu_addr, mvu_wdata,
        input  irq_take, mret, trap_target, return_target
    );

endinterface

`default_nettype wire

//--- hw/csr_cmd_if.sv
`default_nettype none

// decoded command, decode -> execute
interface csr_cmd_if;
    import csr_pkg::*;

    logic     write_en;
    logic     read_en;
    logic     mret;
    csr_sel_e sel;
    // address sits at or above the mvu window start
    logic     mvu_access;
    // access to an address that does not exist
    logic     illegal;

    modport dec (
        output write_en, read_en, mret, sel, mvu_access, illegal
    );

    modport exe (
        input  write_en, read_en, mret, sel, mvu_access, illegal
    );

endinterface

`default_nettype wire

//--- hw/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // ========================================================================
    // csr address map, machine mode only
    // ========================================================================
    // identity words
    localparam logic [11:0] csr_mvendorid = 12'hF11;
    localparam logic [11:0] csr_marchid   = 12'hF12;
    localparam logic [11:0] csr_mimpid    = 12'hF13;
    localparam logic [11:0] csr_mhartid   = 12'hF14;
    // trap setup
    localparam logic [11:0] csr_mstatus   = 12'h300;
    localparam logic [11:0] csr_misa      = 12'h301;
    localparam logic [11:0] csr_mie       = 12'h304;
    localparam logic [11:0] csr_mtvec     = 12'h305;
    // trap handling
    localparam logic [11:0] csr_mepc      = 12'h341;
    localparam logic [11:0] csr_mcause    = 12'h342;
    localparam logic [11:0] csr_mtval     = 12'h343;
    localparam logic [11:0] csr_mip       = 12'h344;
    // cycle counter halves
    localparam logic [11:0] csr_mcycle    = 12'hB00;
    localparam logic [11:0] csr_mcycleh   = 12'hB80;

    // first address of the mvu window, everything above goes out on apb
    localparam logic [11:0] mvu_csr_start = 12'hF20;

    // ========================================================================
    // op codes and register select
    // ========================================================================
    // codes 0, 5, 6, 7 are unused and do nothing
    typedef enum logic [2:0] {
        op_read_write = 3'b001,
        op_set        = 3'b010,
        op_clear      = 3'b011,
        op_mret       = 3'b100
    } csr_op_e;

    // sel_none covers both unknown addresses and the mvu window
    typedef enum logic [3:0] {
        sel_none, sel_mvendorid, sel_marchid, sel_mimpid, sel_mhartid,
        sel_mstatus, sel_misa, sel_mie, sel_mtvec, sel_mepc,
        sel_mcause, sel_mtval, sel_mip, sel_mcycle, sel_mcycleh
    } csr_sel_e;

    // ========================================================================
    // interrupts, causes, identity
    // ========================================================================
    localparam logic [4:0]  irq_m_soft  = 5'd3;
    localparam logic [4:0]  irq_m_timer = 5'd7;
    localparam logic [4:0]  irq_m_ext   = 5'd11;
    localparam logic [4:0]  irq_mvu_bit = 5'd16;

    // only these bits of mie and mip are writable
    localparam logic [31:0] irq_mask = (32'd1 << irq_m_soft) | (32'd1 << irq_m_timer) |
                                       (32'd1 << irq_m_ext) | (32'd1 << irq_mvu_bit);

    localparam logic [31:0] cause_illegal_instr = 32'd2;

    localparam logic [31:0] pito_marchid = 32'd1;
    localparam logic [31:0] hart_id      = 32'd0;
    // mxl = 1 (rv32), extension i
    localparam logic [31:0] isa_code     = 32'h4000_0100;

    // ========================================================================
    // mstatus layout
    // ========================================================================
    typedef struct packed {
        logic        sd;      // 31
        logic [13:0] wpri3;   // 30:17
        logic [1:0]  xs;      // 16:15
        logic [1:0]  fs;      // 14:13
        logic [4:0]  wpri2;   // 12:8, mpp and spp not kept
        logic        mpie;    // 7
        logic [1:0]  wpri1;   // 6:5
        logic        upie;    // 4
        logic        mie;     // 3
        logic [1:0]  wpri0;   // 2:1
        logic        uie;     // 0
    } mstatus_t;

    // same word seen flat or as status fields
    typedef union packed {
        logic [31:0] raw;
        mstatus_t    status;
    } csr_word_u;

endpackage

`default_nettype wire
